// ==== list.f ====
+incdir+src
src/ddr3_rd_pkg.sv
src/ddr3_rd_ctrl.sv
src/ddr3_rd_addr_gen.sv
src/ddr3_rd_fifo.sv
src/ddr3_rd_word_track.sv
src/ddr3_read.sv
sim/ddr3_read_properties.sv
sim/tb_ddr3_read.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the read bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ddr3_read \
    -f list.f \
    -o tb_ddr3_read

./obj_dir/tb_ddr3_read 2>&1 | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim/ddr3_read_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_read_properties (
    input wire                        clk,
    input wire                        rst,
    input wire ddr3_rd_pkg::ddr_cmd_t cmd,
    input wire                        cmd_valid,
    input wire                        cmd_ready,
    input wire ddr3_rd_pkg::rd_resp_t resp,
    input wire                        resp_valid,
    input wire                        req_ready
);

    // a stalled command holds still
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("cmd changed while waiting for cmd_ready");

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        resp.last |-> resp_valid)
        else $error("resp.last high without resp_valid");

    // no new request while a stream is running
    no_req_in_stream: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !req_ready)
        else $error("req_ready high while a word is offered");

endmodule

bind ddr3_read ddr3_read_properties props0 (
    .clk(clk), .rst(rst),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .resp(resp), .resp_valid(resp_valid), .req_ready(req_ready)
);

`default_nettype wire

// ==== sim/tb_ddr3_read.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_settings.svh"

module tb_ddr3_read;

    localparam int WAIT_LIMIT = 4000;   // cycles per wait
    localparam int WPB        = `DDR3_RD_WORDS_PER_BEAT;
    localparam int MAX_BEATS  = `DDR3_RD_MAX_CMD_BEATS;
    localparam logic [31:0] PATTERN = 32'hc3c3_0000;

    logic                    clk = 1'b0;
    logic                    rst;
    ddr3_rd_pkg::rd_req_t    req;
    logic                    req_valid;
    logic                    req_ready;
    ddr3_rd_pkg::rd_resp_t   resp;
    logic                    resp_valid;
    logic                    resp_ready;
    ddr3_rd_pkg::ddr_cmd_t   cmd;
    logic                    cmd_valid;
    logic                    cmd_ready;
    ddr3_rd_pkg::ddr_rdata_t rdata;
    logic                    rdata_valid;

    integer seed     = 32'h5133_4aaf;
    int     errors   = 0;
    int     timeouts = 0;
    logic   rand_ready = 1'b0;              // random cmd_ready and resp_ready
    ddr3_rd_pkg::ddr_cmd_t cmd_log[$];      // commands taken by the model

    always #50 clk = ~clk;

    ddr3_read dut0 (.*);

    // memory contents, word at address a
    function automatic logic [31:0] model_word(input logic [27:0] a);
        return {4'b0000, a} ^ PATTERN;
    endfunction

    task automatic cmp_resp(input ddr3_rd_pkg::rd_resp_t got, input ddr3_rd_pkg::rd_resp_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: resp got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic cmp_cmd(input ddr3_rd_pkg::ddr_cmd_t got, input ddr3_rd_pkg::ddr_cmd_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: cmd got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic cmp_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // controller model, one command in flight
    initial begin : ctrl_model
        ddr3_rd_pkg::ddr_cmd_t  c;
        ddr3_rd_pkg::ddr_beat_u bt;
        logic [31:0]            rnd;
        int                     nb;
        cmd_ready   = 1'b0;
        rdata       = '0;
        rdata_valid = 1'b0;
        forever begin
            @(negedge clk);
            rnd       = $random(seed);
            cmd_ready = rand_ready ? rnd[0] : 1'b1;
            if (!rst && cmd_valid && cmd_ready) begin
                c = cmd;                    // taken at the next rising edge
                cmd_log.push_back(c);
                nb = int'(c.len) + 1;
                @(negedge clk);
                cmd_ready = 1'b0;
                repeat (2) @(negedge clk);  // read latency
                for (int b = 0; b < nb; b++) begin
                    for (int w = 0; w < WPB; w++) begin
                        bt.word[w] = model_word(c.addr + 28'(WPB * b + w));
                    end
                    rdata.beat  = bt;
                    rdata.id    = c.id;
                    rdata.last  = (b == nb - 1);
                    rdata_valid = 1'b1;
                    @(negedge clk);
                end
                rdata_valid = 1'b0;
            end
        end
    end

    task automatic do_reset();
        @(negedge clk);
        rst        = 1'b1;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_req(input logic [3:0] id, input logic [27:0] addr,
                            input logic [7:0] len, output logic ok);
        int n;
        req.id    = id;
        req.addr  = addr;
        req.len   = len;
        req_valid = 1'b1;
        ok        = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            if (req_ready) ok = 1'b1;       // handshake at the next edge
            @(negedge clk);
        end
        req_valid = 1'b0;
        if (!ok) begin
            timeouts++;
            $display("Timeout at %0t: request was never accepted", $time);
        end
    endtask

    // one request, its words and its controller commands
    task automatic run_read(input logic [3:0] id, input logic [27:0] addr, input logic [7:0] len);
        ddr3_rd_pkg::rd_resp_t exp;
        ddr3_rd_pkg::ddr_cmd_t exp_cmd;
        logic [31:0] rnd;
        logic [27:0] beat_a;
        logic        ok;
        int          got_n;
        int          n;
        int          beats;
        int          step;
        cmd_log.delete();
        send_req(id, addr, len, ok);
        if (!ok) return;
        got_n = 0;
        n = 0;
        while (got_n <= int'(len) && n < WAIT_LIMIT) begin
            rnd        = $random(seed);
            resp_ready = rand_ready ? rnd[0] : 1'b1;
            if (resp_valid && resp_ready) begin
                exp.id   = id;
                exp.data = model_word(addr + 28'(got_n));
                exp.resp = 2'b00;
                exp.last = (got_n == int'(len));   // last on the final word only
                cmp_resp(resp, exp);
                got_n++;
                n = 0;
            end else begin
                n++;
            end
            @(negedge clk);
        end
        resp_ready = 1'b0;
        if (got_n <= int'(len)) begin
            timeouts++;
            $display("Timeout at %0t: only %0d of %0d words came back", $time, got_n, len + 1);
            return;
        end
        n = 0;
        while (!req_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("Timeout at %0t: bridge did not return to idle", $time);
            return;
        end
        cmp_bit(resp_valid, 1'b0, "resp_valid");
        // expected commands from the beat span
        beat_a = {addr[27:3], 3'b000};
        beats  = (int'(addr) + int'(len)) / WPB - int'(addr) / WPB + 1;
        while (beats > 0) begin
            step = (beats > MAX_BEATS) ? MAX_BEATS : beats;
            exp_cmd.addr = beat_a;
            exp_cmd.len  = 4'(step - 1);
            exp_cmd.id   = id;
            if (cmd_log.size() == 0) begin
                errors++;
                $display("Missing controller command for beat address %h", beat_a);
            end else begin
                cmp_cmd(cmd_log.pop_front(), exp_cmd);
            end
            beat_a = beat_a + 28'(WPB * step);
            beats  = beats - step;
        end
        if (cmd_log.size() != 0) begin
            errors++;
            $display("%0d more controller commands than expected", cmd_log.size());
        end
    endtask

    task automatic test_aligned();
        rand_ready = 1'b0;
        do_reset();
        run_read(4'h3, 28'h000_0140, 8'd7);
    endtask

    task automatic test_unaligned();
        rand_ready = 1'b0;
        do_reset();
        run_read(4'h5, 28'h002_33a5, 8'd5);   // two beats
    endtask

    task automatic test_long();
        rand_ready = 1'b0;
        do_reset();
        run_read(4'h9, 28'h100_00b3, 8'd255);   // 33 beats
    endtask

    task automatic test_backpressure();
        rand_ready = 1'b1;
        do_reset();
        run_read(4'hc, 28'h040_0017, 8'd99);
    endtask

    task automatic test_back_to_back();
        rand_ready = 1'b1;
        do_reset();
        run_read(4'h1, 28'h000_0806, 8'd20);
        run_read(4'h2, 28'h000_0902, 8'd12);
        run_read(4'he, 28'h000_0a07, 8'd3);
    endtask

    task automatic test_reset_single();
        rand_ready = 1'b1;
        do_reset();
        cmp_bit(cmd_valid, 1'b0, "cmd_valid");
        cmp_bit(resp_valid, 1'b0, "resp_valid");
        cmp_bit(req_ready, 1'b1, "req_ready");
        run_read(4'h7, 28'h0ab_cdef, 8'd0);
    endtask

    initial begin
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        test_aligned();
        test_unaligned();
        test_long();
        test_backpressure();
        test_back_to_back();
        test_reset_single();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/ddr3_rd_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_settings.svh"

module ddr3_rd_addr_gen (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   take_req,
    input  wire ddr3_rd_pkg::rd_req_t req,
    input  wire                   cmd_fire,
    output ddr3_rd_pkg::ddr_cmd_t cmd,
    output logic                  cmd_last
);

    localparam int AW = `DDR3_RD_ADDR_W;
    localparam int RW = 6;   // up to 33 beats per request, kept minus one
    localparam logic [RW-1:0] MAX_M1 = RW'(`DDR3_RD_MAX_CMD_BEATS - 1);

    logic [AW-1:0]   end_addr;     // last requested word
    logic [AW-4:0]   beat_span;
    logic [AW-1:0]   beat_addr;
    logic [RW-1:0]   rem_m1;       // beats still to request, minus one
    logic [3:0]      id_q;
    logic [3:0]      cmd_len;
    logic [4:0]      step;         // beats in this command
    logic [AW-1:0]   step_words;

    assign end_addr   = req.addr + {{(AW - 8){1'b0}}, req.len};
    assign beat_span  = end_addr[AW-1:3] - req.addr[AW-1:3];

    assign cmd_last   = (rem_m1 <= MAX_M1);
    assign cmd_len    = cmd_last ? rem_m1[3:0] : MAX_M1[3:0];
    assign step       = {1'b0, cmd_len} + 5'd1;
    assign step_words = {{(AW - 8){1'b0}}, step, 3'b000};   // 8 words per beat

    assign cmd.addr = beat_addr;
    assign cmd.len  = cmd_len;
    assign cmd.id   = id_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rem_m1 <= '0;
        end else if (take_req) begin
            rem_m1 <= beat_span[RW-1:0];
        end else if (cmd_fire && !cmd_last) begin
            rem_m1 <= rem_m1 - {1'b0, step};
        end
    end

    // payload, loaded per request
    always_ff @(posedge clk) begin
        if (take_req) begin
            beat_addr <= {req.addr[AW-1:3], 3'b000};
            id_q      <= req.id;
        end else if (cmd_fire) begin
            beat_addr <= beat_addr + step_words;
        end
    end

endmodule

`default_nettype wire

// ==== src/ddr3_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_rd_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    // upstream request
    input  wire                    req_valid,
    output logic                   req_ready,
    // controller command
    input  wire                    cmd_ready,
    output logic                   cmd_valid,
    // controller return
    input  wire                    rdata_valid,
    input  wire                    rdata_last,
    // upstream return
    input  wire                    resp_valid,
    input  wire                    resp_ready,
    input  wire                    resp_last,
    // datapath status
    input  wire                    low_level,
    input  wire                    cmd_last,
    output ddr3_rd_pkg::rd_state_e state,
    output logic                   take_req,
    output logic                   fifo_flush
);

    ddr3_rd_pkg::rd_state_e next_state;
    logic                   cmd_done;   // final command already issued
    logic                   cmd_fire;
    logic                   resp_end;   // handshake on the last word

    assign req_ready  = !rst && (state == ddr3_rd_pkg::IDLE);
    assign take_req   = req_valid && req_ready;
    assign cmd_valid  = (state == ddr3_rd_pkg::CMD);
    assign cmd_fire   = cmd_valid && cmd_ready;
    assign resp_end   = resp_valid && resp_ready && resp_last;
    assign fifo_flush = rst || (state == ddr3_rd_pkg::FLUSH);

    always_comb begin
        next_state = state;
        case (state)
            ddr3_rd_pkg::IDLE: begin
                if (take_req) begin
                    next_state = ddr3_rd_pkg::WAIT;
                end
            end
            ddr3_rd_pkg::WAIT: begin
                // stream end wins over a new fetch
                if (resp_end) begin
                    next_state = ddr3_rd_pkg::FLUSH;
                end else if (low_level && !cmd_done) begin
                    next_state = ddr3_rd_pkg::CMD;
                end
            end
            ddr3_rd_pkg::CMD: begin
                if (cmd_fire) begin
                    next_state = ddr3_rd_pkg::FILL;
                end
            end
            ddr3_rd_pkg::FILL: begin
                if (rdata_valid && rdata_last) begin   // burst fully stored
                    next_state = ddr3_rd_pkg::WAIT;
                end
            end
            ddr3_rd_pkg::FLUSH: begin
                next_state = ddr3_rd_pkg::IDLE;     // one cycle only
            end
            default: begin
                next_state = ddr3_rd_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ddr3_rd_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // blocks WAIT -> CMD once the beat count is covered
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_done <= 1'b0;
        end else if (state == ddr3_rd_pkg::IDLE) begin
            cmd_done <= 1'b0;
        end else if (cmd_fire && cmd_last) begin
            cmd_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/ddr3_rd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_rd_settings.svh"

module ddr3_rd_fifo (
    input  wire                        clk,
    input  wire                        flush,
    input  wire                        wr_en,
    input  wire ddr3_rd_pkg::ddr_beat_u wr_beat,
    input  wire                        rd_en,
    output logic [31:0]                rd_word,
    output logic                       empty,
    output logic                       low_level
);

    localparam int DEPTH = `DDR3_RD_FIFO_BEATS;
    localparam int PW    = $clog2(DEPTH);
    localparam int WPB   = `DDR3_RD_WORDS_PER_BEAT;
    localparam int IW    = $clog2(WPB);
    localparam logic [IW-1:0] LAST_WORD = IW'(WPB - 1);
    localparam logic [PW:0]   REFILL    = (PW + 1)'(`DDR3_RD_REFILL_LEVEL);

    ddr3_rd_pkg::ddr_beat_u mem [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;      // whole beats held, incl. the one being read
    logic [IW-1:0] word_idx;   // next word of the head beat
    logic          beat_pop;

    // show-ahead output straight from the head beat
    assign rd_word   = mem[rd_ptr].word[word_idx];
    assign empty     = (count == '0);
    assign low_level = (count <= REFILL);
    assign beat_pop  = rd_en && (word_idx == LAST_WORD);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + PW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            rd_ptr   <= '0;
            word_idx <= '0;
        end else if (rd_en) begin
            word_idx <= word_idx + IW'(1);   // wraps to 0 after word 7
            if (beat_pop) begin
                rd_ptr <= rd_ptr + PW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            count <= '0;
        end else begin
            case ({wr_en, beat_pop})
                2'b10:   count <= count + (PW + 1)'(1);
                2'b01:   count <= count - (PW + 1)'(1);
                default: count <= count;   // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/ddr3_rd_pkg.sv ====
`default_nettype none

package ddr3_rd_pkg;

    `include "ddr3_rd_settings.svh"

    // upstream read request, len is words minus one
    typedef struct packed {
        logic [3:0]                   id;
        logic [`DDR3_RD_ADDR_W-1:0]   addr;
        logic [7:0]                   len;
    } rd_req_t;

    // one returned word upstream
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } rd_resp_t;

    // controller command, addr is beat aligned
    typedef struct packed {
        logic [`DDR3_RD_ADDR_W-1:0] addr;
        logic [3:0]                 len;   // beats minus one
        logic [3:0]                 id;
    } ddr_cmd_t;

    // a beat seen either whole or as words, word 0 at the lowest address
    typedef union packed {
        logic [`DDR3_RD_BEAT_W-1:0]                          raw;
        logic [`DDR3_RD_WORDS_PER_BEAT-1:0][31:0]            word;
    } ddr_beat_u;

    typedef struct packed {
        ddr_beat_u  beat;
        logic [3:0] id;
        logic       last;
    } ddr_rdata_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        CMD,
        FILL,
        FLUSH
    } rd_state_e;

endpackage

`default_nettype wire

// ==== src/ddr3_rd_settings.svh ====
`ifndef DDR3_RD_SETTINGS_SVH
`define DDR3_RD_SETTINGS_SVH

// word address width on the upstream and controller side
`define DDR3_RD_ADDR_W 28

// controller data beat
`define DDR3_RD_BEAT_W 256
`define DDR3_RD_WORDS_PER_BEAT 8

// longest controller command, len field is 4 bits
`define DDR3_RD_MAX_CMD_BEATS 16

// beat FIFO depth and the level at or below which a command may go out
`define DDR3_RD_FIFO_BEATS 32
`define DDR3_RD_REFILL_LEVEL 16

`endif

// ==== src/ddr3_rd_word_track.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_rd_word_track (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        take_req,
    input  wire ddr3_rd_pkg::rd_req_t  req,
    input  wire ddr3_rd_pkg::rd_state_e state,
    input  wire                        empty,
    input  wire                        resp_ready,
    output logic                       rd_en,
    output logic                       resp_valid,
    output logic                       resp_last
);

    logic [2:0] discard;     // leading words before the start address
    logic [7:0] remain;      // words left after the current one
    logic       active;
    logic       dropping;

    assign active   = (state != ddr3_rd_pkg::IDLE) && (state != ddr3_rd_pkg::FLUSH);
    assign dropping = active && (discard != 3'd0);

    assign resp_valid = active && !empty && (discard == 3'd0);
    assign resp_last  = resp_valid && (remain == 8'd0);
    assign rd_en      = (dropping && !empty) || (resp_valid && resp_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            discard <= 3'd0;
            remain  <= 8'd0;
        end else if (take_req) begin
            discard <= req.addr[2:0];
            remain  <= req.len;
        end else if (rd_en) begin
            if (dropping) begin
                discard <= discard - 3'd1;   // one dropped word per cycle
            end else if (remain != 8'd0) begin
                remain <= remain - 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ddr3_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_read (
    input  wire                          clk,
    input  wire                          rst,
    // upstream side
    input  wire ddr3_rd_pkg::rd_req_t    req,
    input  wire                          req_valid,
    output logic                         req_ready,
    output ddr3_rd_pkg::rd_resp_t        resp,
    output logic                         resp_valid,
    input  wire                          resp_ready,
    // memory controller side
    output ddr3_rd_pkg::ddr_cmd_t        cmd,
    output logic                         cmd_valid,
    input  wire                          cmd_ready,
    input  wire ddr3_rd_pkg::ddr_rdata_t rdata,
    input  wire                          rdata_valid
);

    ddr3_rd_pkg::rd_state_e state;
    logic        take_req;
    logic        fifo_flush;
    logic        cmd_fire;
    logic        cmd_last;
    logic        fifo_wr;
    logic        low_level;
    logic        empty;
    logic        rd_en;
    logic        resp_last;
    logic [31:0] rd_word;

    assign cmd_fire = cmd_valid && cmd_ready;
    assign fifo_wr  = rdata_valid && (state == ddr3_rd_pkg::FILL);   // no stray beats

    // id is echoed from the registered request
    assign resp.id   = cmd.id;
    assign resp.data = rd_word;
    assign resp.resp = 2'b00;
    assign resp.last = resp_last;

    ddr3_rd_ctrl ctrl0 (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready),
        .cmd_ready(cmd_ready), .cmd_valid(cmd_valid),
        .rdata_valid(rdata_valid), .rdata_last(rdata.last),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_last(resp_last),
        .low_level(low_level), .cmd_last(cmd_last),
        .state(state), .take_req(take_req), .fifo_flush(fifo_flush)
    );

    ddr3_rd_addr_gen addr0 (
        .clk(clk), .rst(rst), .take_req(take_req), .req(req),
        .cmd_fire(cmd_fire), .cmd(cmd), .cmd_last(cmd_last)
    );

    ddr3_rd_fifo fifo0 (
        .clk(clk), .flush(fifo_flush),
        .wr_en(fifo_wr), .wr_beat(rdata.beat),
        .rd_en(rd_en), .rd_word(rd_word), .empty(empty), .low_level(low_level)
    );

    ddr3_rd_word_track track0 (
        .clk(clk), .rst(rst), .take_req(take_req), .req(req), .state(state),
        .empty(empty), .resp_ready(resp_ready), .rd_en(rd_en),
        .resp_valid(resp_valid), .resp_last(resp_last)
    );

endmodule

`default_nettype wire
